// ==== build.f ====
+incdir+design
design/corePkg.sv
design/programLoader.sv
design/registerFile.sv
design/fetchStage.sv
design/execStage.sv
design/memStage.sv
design/pipelineTop.sv
tb/pipelineProperties.sv
tb/pipelineTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f build.f --top-module pipelineTb
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/VpipelineTb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb/pipelineTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "coreDefines.svh"

module pipelineTb
   import corePkg::*;
;

   // pipe depth plus one is enough for any stray commit to show up
   localparam int quietCycles = 4;

   logic      clk;
   logic      reset;
   logic      run;
   logic      loadReq;
   loadWordT  loadData;
   logic      loadAck;
   commitT    commit;

   instrWordT prog [$];
   commitT    expQ [$];
   int        seed = 71;
   int        mismatchCount = 0;
   int        failureCount = 0;
   int        cycleCount = 0;
   int        cycleLimit = 0;
   logic      verdictDone = 1'b0;

   pipelineTop dut_i (
      .clk      (clk),
      .reset    (reset),
      .run      (run),
      .loadReq  (loadReq),
      .loadData (loadData),
      .loadAck  (loadAck),
      .commit   (commit)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // watchdog limit grows as each test announces its length
   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("run stopped after %0d cycles, limit was %0d", cycleCount, cycleLimit);
         verdictDone = 1'b1;
         $display("Test failed");
         $finish;
      end
   end

   // no verdict printed yet when the simulation ends early
   final begin
      if (!verdictDone) begin
         $display("Test failed");
      end
   end

   function automatic instrWordT makeR(logic [5:0] funct, int rd, int rs, int rt);
      instrWordT w;
      w.rFmt.opcode = `OP_RTYPE;
      w.rFmt.rs     = rs[4:0];
      w.rFmt.rt     = rt[4:0];
      w.rFmt.rd     = rd[4:0];
      w.rFmt.shamt  = 5'd0;
      w.rFmt.funct  = funct;
      return w;
   endfunction

   // operands in assembly order rt then rs then imm
   function automatic instrWordT makeI(logic [5:0] op, int rt, int rs, logic [15:0] imm);
      instrWordT w;
      w.iFmt.opcode = op;
      w.iFmt.rs     = rs[4:0];
      w.iFmt.rt     = rt[4:0];
      w.iFmt.imm16  = imm;
      return w;
   endfunction

   function automatic instrWordT makeJ(logic [5:0] op, int index);
      instrWordT w;
      w.jFmt.opcode   = op;
      w.jFmt.target26 = index[25:0];
      return w;
   endfunction

   // offset counted from the delay slot
   function automatic instrWordT branchTo(logic [5:0] op, int rs, int rt, int from, int to);
      int off;
      off = to - from - 1;
      return makeI(op, rt, rs, off[15:0]);
   endfunction

   function automatic logic [31:0] sext16(logic [15:0] h);
      return {{16{h[15]}}, h};
   endfunction

   function automatic logic [31:0] zext16(logic [15:0] h);
      return {16'h0000, h};
   endfunction

   function automatic void emit(instrWordT w);
      prog.push_back(w);
   endfunction

   function automatic void newProgram();
      prog.delete();
      expQ.delete();
   endfunction

   // jump to itself with sll r0 in the delay slot
   function automatic void endLoop();
      emit(makeJ(`OP_J, prog.size()));
      emit(makeR(6'h00, 0, 0, 0));
   endfunction

   function automatic void expectWrite(int dest, logic [31:0] value);
      commitT c;
      c.valid = 1'b1;
      c.dest  = dest[4:0];
      c.value = value;
      expQ.push_back(c);
   endfunction

   task automatic compareCommit(string name, int index, commitT expected, commitT actual);
      if (expected !== actual) begin
         mismatchCount++;
         $write("mismatch %s commit %0d: expected valid %0b dest %0d value %h, ",
                name, index, expected.valid, expected.dest, expected.value);
         $display("actual valid %0b dest %0d value %h",
                  actual.valid, actual.dest, actual.value);
      end
   endtask

   task automatic compareCount(string name, int expected, int actual);
      if (expected != actual) begin
         mismatchCount++;
         $display("mismatch %s commit count: expected %0d, actual %0d",
                  name, expected, actual);
      end
   endtask

   task automatic applyReset();
      @(negedge clk);
      reset   = 1'b0;
      run     = 1'b0;
      loadReq = 1'b0;
      repeat (8) @(negedge clk);
      reset = 1'b1;
   endtask

   // up to 10 cycles for the ack edge
   task automatic waitForAck(logic level);
      int n;
      for (n = 0; n < 10 && loadAck !== level; n++) begin
         @(negedge clk);
      end
      if (loadAck !== level) begin
         failureCount++;
         $display("loadAck did not %s within 10 cycles", level ? "rise" : "fall");
      end
   endtask

   // four-phase handshake per word
   task automatic loadProgram();
      int i;
      for (i = 0; i < prog.size(); i++) begin
         loadData.addr = i[`IMEM_AW-1:0];
         loadData.word = prog[i];
         loadReq = 1'b1;
         waitForAck(1'b1);
         loadReq = 1'b0;
         waitForAck(1'b0);
      end
   endtask

   task automatic runProgram(string name, int idleCycles);
      commitT gotQ [$];
      int     waited;
      int     idleCommits;
      int     i;
      // budget covers reset, two cycles a word for the load, idle time, run and drain
      cycleLimit += 10 + 5 * prog.size() + idleCycles + 40 + quietCycles;
      applyReset();
      loadProgram();
      idleCommits = 0;
      repeat (idleCycles) begin
         @(negedge clk);
         if (commit.valid) idleCommits++;
      end
      if (idleCycles > 0) begin
         compareCount({name, " while stopped"}, 0, idleCommits);
      end
      run = 1'b1;
      waited = 0;
      while (gotQ.size() < expQ.size() && waited < prog.size() + 40) begin
         @(negedge clk);
         waited++;
         if (commit.valid) gotQ.push_back(commit);
      end
      if (gotQ.size() < expQ.size()) begin
         failureCount++;
         $display("%s: only %0d of %0d commits arrived before the wait ran out",
                  name, gotQ.size(), expQ.size());
      end
      // skipped or stray instructions would land here
      repeat (quietCycles) begin
         @(negedge clk);
         if (commit.valid) gotQ.push_back(commit);
      end
      run = 1'b0;
      compareCount(name, expQ.size(), gotQ.size());
      for (i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
         compareCommit(name, i, expQ[i], gotQ[i]);
      end
   endtask

   // each result feeds the next through forwarding and the bypass
   task automatic testAluChain();
      logic [31:0] rnd;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] c;
      logic [31:0] v [1:10];
      int          i;
      newProgram();
      rnd = $random(seed);
      a = rnd[15:0];
      b = rnd[31:16];
      rnd = $random(seed);
      c = rnd[15:0];
      emit(makeI(`OP_ADDIU, 1, 0, a));
      emit(makeI(`OP_ORI, 2, 1, b));
      emit(makeI(`OP_LUI, 3, 0, c));
      emit(makeR(`FN_ADDU, 4, 3, 2));
      emit(makeR(`FN_SUBU, 5, 4, 1));
      emit(makeR(`FN_AND, 6, 5, 2));
      emit(makeR(`FN_XOR, 7, 6, 4));
      emit(makeR(`FN_SLT, 8, 7, 1));
      emit(makeI(`OP_ANDI, 9, 7, b));
      emit(makeI(`OP_XORI, 10, 9, a));
      endLoop();
      v[1]  = sext16(a);
      v[2]  = v[1] | zext16(b);
      v[3]  = {c, 16'h0000};
      v[4]  = v[3] + v[2];
      v[5]  = v[4] - v[1];
      v[6]  = v[5] & v[2];
      v[7]  = v[6] ^ v[4];
      v[8]  = ($signed(v[7]) < $signed(v[1])) ? 32'd1 : 32'd0;
      v[9]  = v[7] & zext16(b);
      v[10] = v[9] ^ zext16(a);
      for (i = 1; i <= 10; i++) begin
         expectWrite(i, v[i]);
      end
      runProgram("alu chain", 0);
   endtask

   // word and byte lanes with each load used right away
   task automatic testMemory();
      logic [31:0] rnd;
      logic [31:0] w;
      logic [7:0]  bk;
      logic [31:0] sb;
      int          k;
      int          off;
      newProgram();
      w = $random(seed);
      emit(makeI(`OP_ADDIU, 1, 0, 16'h0040));
      emit(makeI(`OP_LUI, 2, 0, w[31:16]));
      emit(makeI(`OP_ORI, 2, 2, w[15:0]));
      emit(makeI(`OP_SW, 2, 1, 16'h0000));
      emit(makeI(`OP_LW, 3, 1, 16'h0000));
      emit(makeR(`FN_ADDU, 4, 3, 3));
      expectWrite(1, 32'h0000_0040);
      expectWrite(2, {w[31:16], 16'h0000});
      expectWrite(2, w);
      expectWrite(3, w);
      expectWrite(4, w + w);
      for (k = 0; k < 4; k++) begin
         rnd = $random(seed);
         bk = rnd[7:0];
         // both signs covered
         bk[7] = k[0];
         off = 4 + k;
         emit(makeI(`OP_ADDIU, 5, 0, {8'h00, bk}));
         emit(makeI(`OP_SB, 5, 1, off[15:0]));
         emit(makeI(`OP_LB, 6, 1, off[15:0]));
         emit(makeR(`FN_ADDU, 7, 6, 1));
         emit(makeI(`OP_LBU, 8, 1, off[15:0]));
         emit(makeR(`FN_ADDU, 9, 8, 8));
         sb = {{24{bk[7]}}, bk};
         expectWrite(5, {24'h000000, bk});
         expectWrite(6, sb);
         expectWrite(7, sb + 32'h0000_0040);
         expectWrite(8, {24'h000000, bk});
         expectWrite(9, {23'h000000, bk, 1'b0});
      end
      endLoop();
      runProgram("memory", 0);
   endtask

   // taken and not-taken branches with delay slots that always commit
   task automatic testBranches();
      logic [31:0] rnd;
      logic [31:0] x;
      newProgram();
      rnd = $random(seed);
      x = sext16(rnd[15:0]);
      emit(makeI(`OP_ADDIU, 1, 0, rnd[15:0]));
      emit(makeI(`OP_ADDIU, 2, 0, rnd[15:0]));
      emit(makeI(`OP_ADDIU, 3, 1, 16'h0001));
      emit(branchTo(`OP_BEQ, 1, 2, 3, 6));
      emit(makeI(`OP_ADDIU, 4, 0, 16'd11));
      emit(makeI(`OP_ADDIU, 5, 0, 16'd99));
      emit(branchTo(`OP_BEQ, 1, 3, 6, 10));
      emit(makeI(`OP_ADDIU, 6, 0, 16'd12));
      emit(makeI(`OP_ADDIU, 7, 0, 16'd13));
      emit(branchTo(`OP_BNE, 1, 3, 9, 12));
      emit(makeI(`OP_ADDIU, 8, 0, 16'd14));
      emit(makeI(`OP_ADDIU, 9, 0, 16'd98));
      emit(branchTo(`OP_BNE, 1, 2, 12, 15));
      emit(makeI(`OP_ADDIU, 10, 0, 16'd15));
      emit(makeI(`OP_ADDIU, 11, 0, 16'd16));
      endLoop();
      expectWrite(1, x);
      expectWrite(2, x);
      expectWrite(3, x + 32'd1);
      expectWrite(4, 32'd11);
      expectWrite(6, 32'd12);
      expectWrite(7, 32'd13);
      expectWrite(8, 32'd14);
      expectWrite(10, 32'd15);
      expectWrite(11, 32'd16);
      runProgram("branches", 0);
   endtask

   // jal links past its delay slot and jr returns through r1
   task automatic testJumps();
      newProgram();
      emit(makeI(`OP_ADDIU, 1, 0, 16'd44));
      emit(makeJ(`OP_JAL, 5));
      emit(makeI(`OP_ADDIU, 2, 0, 16'd21));
      emit(makeI(`OP_ADDIU, 3, 0, 16'd77));
      emit(makeI(`OP_ADDIU, 3, 0, 16'd78));
      emit(makeR(`FN_ADDU, 4, 31, 0));
      emit(makeR(`FN_JR, 0, 1, 0));
      emit(makeI(`OP_ADDIU, 5, 0, 16'd22));
      emit(makeI(`OP_ADDIU, 6, 0, 16'd79));
      emit(makeI(`OP_ADDIU, 6, 0, 16'd80));
      emit(makeI(`OP_ADDIU, 6, 0, 16'd81));
      emit(makeJ(`OP_J, 14));
      emit(makeI(`OP_ADDIU, 7, 0, 16'd23));
      emit(makeI(`OP_ADDIU, 8, 0, 16'd82));
      emit(makeI(`OP_ADDIU, 9, 4, 16'd1));
      endLoop();
      expectWrite(1, 32'd44);
      // jal at byte 4
      expectWrite(31, 32'd12);
      expectWrite(2, 32'd21);
      expectWrite(4, 32'd12);
      expectWrite(5, 32'd22);
      expectWrite(7, 32'd23);
      expectWrite(9, 32'd13);
      runProgram("jumps", 0);
   endtask

   // r0 writes vanish and r0 still reads zero
   task automatic testResetAndZero();
      logic [31:0] rnd;
      newProgram();
      rnd = $random(seed);
      // word 0 writes r1, so a fetch leaking through while stopped would commit
      emit(makeI(`OP_ADDIU, 1, 0, 16'h0003));
      emit(makeI(`OP_ADDIU, 0, 0, rnd[15:0]));
      emit(makeI(`OP_ORI, 0, 0, rnd[31:16]));
      emit(makeR(`FN_ADDU, 2, 0, 0));
      emit(makeI(`OP_LUI, 0, 0, rnd[15:0]));
      emit(makeR(`FN_OR, 3, 0, 1));
      endLoop();
      expectWrite(1, 32'd3);
      expectWrite(2, 32'd0);
      expectWrite(3, 32'd3);
      runProgram("reset and r0", 10);
   endtask

   initial begin
      reset    = 1'b0;
      run      = 1'b0;
      loadReq  = 1'b0;
      loadData = '0;
      testAluChain();
      testMemory();
      testBranches();
      testJumps();
      testResetAndZero();
      $display("summary: %0d mismatches, %0d other failures", mismatchCount, failureCount);
      verdictDone = 1'b1;
      if (mismatchCount == 0 && failureCount == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/pipelineProperties.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineProperties
   import corePkg::*;
(
   input logic   clk,
   input logic   reset,
   input logic   loadReq,
   input logic   loadAck,
   input commitT commit
);

   // ack only answers a pending request
   ackRiseNeedsReq: assert property (
      @(posedge clk) disable iff (!reset)
      $rose(loadAck) |-> $past(loadReq)
   ) else $error("loadAck rose while loadReq was low");

   // ack held until the request is withdrawn
   ackFallNeedsNoReq: assert property (
      @(posedge clk) disable iff (!reset)
      $fell(loadAck) |-> !$past(loadReq)
   ) else $error("loadAck fell while loadReq was still high");

   // r0 writes never reach the commit port
   commitNotToZero: assert property (
      @(posedge clk) disable iff (!reset)
      commit.valid |-> commit.dest != '0
   ) else $error("commit raised for register zero");

   // synchronous reset, so quiet from the cycle after
   noCommitInReset: assert property (
      @(posedge clk)
      !reset |=> !commit.valid
   ) else $error("commit raised while in reset");

endmodule

bind pipelineTop pipelineProperties props_i (
   .clk     (clk),
   .reset   (reset),
   .loadReq (loadReq),
   .loadAck (loadAck),
   .commit  (commit)
);

`default_nettype wire

// ==== design/pipelineTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "coreDefines.svh"

module pipelineTop
   import corePkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     run,
   input  logic     loadReq,
   input  loadWordT loadData,
   output logic     loadAck,
   output commitT   commit
);

   imemWriteT          imemWrite;
   redirectT           redirect;
   logic [`REG_AW-1:0] readAddrA;
   logic [`REG_AW-1:0] readAddrB;
   logic [`WORD_W-1:0] readDataA;
   logic [`WORD_W-1:0] readDataB;
   fetchToExecT        toExec;
   memReqT             memReq;
   execToMemT          toMem;

   // program load port into instruction memory
   programLoader loader_i (
      .clk       (clk),
      .reset     (reset),
      .run       (run),
      .loadReq   (loadReq),
      .loadData  (loadData),
      .loadAck   (loadAck),
      .imemWrite (imemWrite)
   );

   // PC, decode, register read
   fetchStage fetch_i (
      .clk       (clk),
      .reset     (reset),
      .run       (run),
      .imemWrite (imemWrite),
      .redirect  (redirect),
      .commit    (commit),
      .readAddrA (readAddrA),
      .readAddrB (readAddrB),
      .readDataA (readDataA),
      .readDataB (readDataB),
      .toExec    (toExec)
   );

   // written by commit
   registerFile regFile_i (
      .clk       (clk),
      .reset     (reset),
      .readAddrA (readAddrA),
      .readAddrB (readAddrB),
      .readDataA (readDataA),
      .readDataB (readDataB),
      .commit    (commit)
   );

   execStage exec_i (
      .clk       (clk),
      .reset     (reset),
      .fromFetch (toExec),
      .commit    (commit),
      .redirect  (redirect),
      .memReq    (memReq),
      .toMem     (toMem)
   );

   // data memory and write-back
   memStage mem_i (
      .clk      (clk),
      .reset    (reset),
      .memReq   (memReq),
      .fromExec (toMem),
      .commit   (commit)
   );

endmodule

`default_nettype wire

// ==== design/memStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "coreDefines.svh"

module memStage
   import corePkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  memReqT    memReq,
   input  execToMemT fromExec,
   output commitT    commit
);

   logic [`WORD_W-1:0] dmem [0:(1<<`DMEM_AW)-1];
   logic [`WORD_W-1:0] readWord;
   logic [7:0]         loadByte;
   logic [`WORD_W-1:0] loadData;
   logic [`WORD_W-1:0] wbValue;

   // byte-lane writes, read registered alongside E/M
   // old data on a same-edge collision, a store then load sees the new word
   always_ff @(posedge clk) begin
      for (int lane = 0; lane < 4; lane++) begin
         if (reset && memReq.byteEn[lane]) begin
            dmem[memReq.addr][8*lane +: 8] <= memReq.wdata[8*lane +: 8];
         end
      end
      readWord <= dmem[memReq.addr];
   end

   // pick the addressed lane
   assign loadByte = readWord[{fromExec.byteOffset, 3'b000} +: 8];

   always_comb begin
      case (fromExec.memKind)
         memLoadByte:  loadData = {{24{loadByte[7]}}, loadByte};
         memLoadByteU: loadData = {24'b0, loadByte};
         default:      loadData = readWord;
      endcase
   end

   // link beats load beats ALU
   always_comb begin
      if (fromExec.link) begin
         wbValue = fromExec.linkValue;
      end else if (fromExec.memKind inside {memLoadWord, memLoadByte, memLoadByteU}) begin
         wbValue = loadData;
      end else begin
         wbValue = fromExec.aluResult;
      end
   end

   // writes to r0 vanish here
   always_comb begin
      commit.valid = fromExec.regWrite && fromExec.dest != '0;
      commit.dest  = fromExec.dest;
      commit.value = wbValue;
   end

endmodule

`default_nettype wire

// ==== design/execStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "coreDefines.svh"

module execStage
   import corePkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  fetchToExecT fromFetch,
   input  commitT      commit,
   output redirectT    redirect,
   output memReqT      memReq,
   output execToMemT   toMem
);

   logic [`WORD_W-1:0] rsVal;
   logic [`WORD_W-1:0] rtVal;
   logic [`WORD_W-1:0] opB;
   logic [`WORD_W-1:0] aluResult;
   logic [`WORD_W-1:0] pcPlus4;
   logic               branchTaken;

   // forward the final write-back of the instruction in memory
   // covers load results too, so no load-use stall
   assign rsVal = (commit.valid && commit.dest == fromFetch.rs) ? commit.value : fromFetch.rd1;
   assign rtVal = (commit.valid && commit.dest == fromFetch.rt) ? commit.value : fromFetch.rd2;

   assign opB = fromFetch.ctl.useImm ? fromFetch.imm : rtVal;

   always_comb begin
      case (fromFetch.ctl.aluOp)
         aluSub:  aluResult = rsVal - opB;
         aluAnd:  aluResult = rsVal & opB;
         aluOr:   aluResult = rsVal | opB;
         aluXor:  aluResult = rsVal ^ opB;
         aluSlt:  aluResult = {31'b0, $signed(rsVal) < $signed(opB)};
         // upper half from the immediate
         aluLui:  aluResult = {opB[15:0], 16'b0};
         default: aluResult = rsVal + opB;
      endcase
   end

   assign pcPlus4 = fromFetch.pc + `WORD_W'd4;

   assign branchTaken = (fromFetch.ctl.isBranchEq && rsVal == rtVal) ||
                        (fromFetch.ctl.isBranchNe && rsVal != rtVal);

   // target applies after the delay slot
   always_comb begin
      redirect.valid  = branchTaken || fromFetch.ctl.isJump || fromFetch.ctl.isJumpReg;
      redirect.target = pcPlus4 + {fromFetch.imm[`WORD_W-3:0], 2'b00};
      if (fromFetch.ctl.isJump) begin
         redirect.target = {pcPlus4[31:28], fromFetch.target26, 2'b00};
      end else if (fromFetch.ctl.isJumpReg) begin
         redirect.target = rsVal;
      end
   end

   // store request, byte lane 0 is address offset 0
   always_comb begin
      memReq.addr   = aluResult[`DMEM_AW+1:2];
      memReq.wdata  = rtVal;
      memReq.byteEn = 4'b0000;
      case (fromFetch.ctl.memKind)
         memStoreWord: memReq.byteEn = 4'b1111;
         memStoreByte: begin
            // same byte on every lane, enable picks one
            memReq.wdata  = {4{rtVal[7:0]}};
            memReq.byteEn = 4'b0001 << aluResult[1:0];
         end
         default: memReq.byteEn = 4'b0000;
      endcase
   end

   // E/M register
   always_ff @(posedge clk) begin
      if (!reset) begin
         toMem.regWrite <= 1'b0;
         toMem.memKind  <= memNone;
      end else begin
         toMem.regWrite <= fromFetch.ctl.regWrite;
         toMem.memKind  <= fromFetch.ctl.memKind;
      end
      toMem.dest       <= fromFetch.ctl.dest;
      toMem.byteOffset <= aluResult[1:0];
      toMem.link       <= fromFetch.ctl.linkPc;
      toMem.aluResult  <= aluResult;
      // return past the delay slot
      toMem.linkValue  <= fromFetch.pc + `WORD_W'd8;
   end

endmodule

`default_nettype wire

// ==== design/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "coreDefines.svh"

module fetchStage
   import corePkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               run,
   input  imemWriteT          imemWrite,
   input  redirectT           redirect,
   input  commitT             commit,
   output logic [`REG_AW-1:0] readAddrA,
   output logic [`REG_AW-1:0] readAddrB,
   input  logic [`WORD_W-1:0] readDataA,
   input  logic [`WORD_W-1:0] readDataB,
   output fetchToExecT        toExec
);

   logic [`WORD_W-1:0] pc;
   logic [`WORD_W-1:0] imem [0:(1<<`IMEM_AW)-1];
   instrWordT          instr;
   execCtlT            ctl;
   logic [`WORD_W-1:0] immExt;
   logic [`WORD_W-1:0] rd1;
   logic [`WORD_W-1:0] rd2;

   // PC parked at 0 until run
   // redirect from execute lands after the delay slot was fetched
   always_ff @(posedge clk) begin
      if (!reset || !run) begin
         pc <= '0;
      end else if (redirect.valid) begin
         pc <= redirect.target;
      end else begin
         pc <= pc + `WORD_W'd4;
      end
   end

   // loader port, only written while stopped
   always_ff @(posedge clk) begin
      if (imemWrite.en) begin
         imem[imemWrite.addr] <= imemWrite.word;
      end
   end

   // asynchronous read at the word index of the PC
   assign instr = imem[pc[`IMEM_AW+1:2]];

   // decode
   always_comb begin
      ctl        = '0;
      ctl.aluOp  = aluAdd;
      ctl.dest   = instr.iFmt.rt;
      // most immediates sign extend
      immExt     = {{16{instr.iFmt.imm16[15]}}, instr.iFmt.imm16};
      case (instr.rFmt.opcode)
         `OP_RTYPE: begin
            ctl.regWrite = 1'b1;
            ctl.dest     = instr.rFmt.rd;
            case (instr.rFmt.funct)
               `FN_SUBU: ctl.aluOp = aluSub;
               `FN_AND:  ctl.aluOp = aluAnd;
               `FN_OR:   ctl.aluOp = aluOr;
               `FN_XOR:  ctl.aluOp = aluXor;
               `FN_SLT:  ctl.aluOp = aluSlt;
               `FN_JR: begin
                  ctl.regWrite  = 1'b0;
                  ctl.isJumpReg = 1'b1;
               end
               `FN_JALR: begin
                  ctl.isJumpReg = 1'b1;
                  ctl.linkPc    = 1'b1;
               end
               // addu and anything unknown
               default:  ctl.aluOp = aluAdd;
            endcase
         end
         `OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
            ctl.regWrite = 1'b1;
            ctl.useImm   = 1'b1;
            case (instr.rFmt.opcode)
               `OP_SLTI: ctl.aluOp = aluSlt;
               `OP_ANDI: ctl.aluOp = aluAnd;
               `OP_ORI:  ctl.aluOp = aluOr;
               `OP_XORI: ctl.aluOp = aluXor;
               `OP_LUI:  ctl.aluOp = aluLui;
               default:  ctl.aluOp = aluAdd;
            endcase
            // logical immediates zero extend
            if (instr.rFmt.opcode inside {`OP_ANDI, `OP_ORI, `OP_XORI}) begin
               immExt = {16'b0, instr.iFmt.imm16};
            end
         end
         `OP_LW, `OP_LB, `OP_LBU: begin
            ctl.regWrite = 1'b1;
            ctl.useImm   = 1'b1;
            ctl.memKind  = (instr.rFmt.opcode == `OP_LW) ? memLoadWord :
                           (instr.rFmt.opcode == `OP_LB) ? memLoadByte : memLoadByteU;
         end
         `OP_SW, `OP_SB: begin
            ctl.useImm  = 1'b1;
            ctl.memKind = (instr.rFmt.opcode == `OP_SW) ? memStoreWord : memStoreByte;
         end
         `OP_BEQ: ctl.isBranchEq = 1'b1;
         `OP_BNE: ctl.isBranchNe = 1'b1;
         `OP_J:   ctl.isJump     = 1'b1;
         `OP_JAL: begin
            ctl.isJump   = 1'b1;
            ctl.linkPc   = 1'b1;
            ctl.regWrite = 1'b1;
            ctl.dest     = `LINK_REG;
         end
         default: ctl = '0;
      endcase
   end

   assign readAddrA = instr.rFmt.rs;
   assign readAddrB = instr.rFmt.rt;

   // bypass the write happening this same cycle
   assign rd1 = (commit.valid && commit.dest == readAddrA) ? commit.value : readDataA;
   assign rd2 = (commit.valid && commit.dest == readAddrB) ? commit.value : readDataB;

   // F/E register, control cleared to a bubble while stopped
   always_ff @(posedge clk) begin
      if (!reset || !run) begin
         toExec.ctl <= '0;
      end else begin
         toExec.ctl <= ctl;
      end
      toExec.rs       <= readAddrA;
      toExec.rt       <= readAddrB;
      toExec.rd1      <= rd1;
      toExec.rd2      <= rd2;
      toExec.imm      <= immExt;
      toExec.target26 <= instr.jFmt.target26;
      toExec.pc       <= pc;
   end

endmodule

`default_nettype wire

// ==== design/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "coreDefines.svh"

module registerFile
   import corePkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic [`REG_AW-1:0] readAddrA,
   input  logic [`REG_AW-1:0] readAddrB,
   output logic [`WORD_W-1:0] readDataA,
   output logic [`WORD_W-1:0] readDataB,
   input  commitT             commit
);

   // r0 has no storage
   logic [`WORD_W-1:0] regs [1:31];

   // write at the end of the commit cycle
   // held off during reset, the pipe may still carry garbage
   always_ff @(posedge clk) begin
      if (reset && commit.valid && commit.dest != '0) begin
         regs[commit.dest] <= commit.value;
      end
   end

   // asynchronous reads, r0 forced to zero
   assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// ==== design/programLoader.sv ====
`timescale 1ns/1ps
`default_nettype none

module programLoader
   import corePkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      run,
   input  logic      loadReq,
   input  loadWordT  loadData,
   output logic      loadAck,
   output imemWriteT imemWrite
);

   // loadAck is the state bit itself
   // low  = waiting for a request
   // high = acknowledged, waiting for loadReq to drop
   always_ff @(posedge clk) begin
      if (!reset) begin
         loadAck <= 1'b0;
      end else if (!loadAck) begin
         // requests are ignored while the core is running
         loadAck <= loadReq && !run;
      end else begin
         loadAck <= loadReq;
      end
   end

   // single write, on the edge that raises loadAck
   always_comb begin
      imemWrite.en   = loadReq && !loadAck && !run;
      imemWrite.addr = loadData.addr;
      imemWrite.word = loadData.word;
   end

endmodule

`default_nettype wire

// ==== design/corePkg.sv ====
`default_nettype none
`include "coreDefines.svh"

package corePkg;

   // register-format view
   typedef struct packed {
      logic [5:0]         opcode;
      logic [`REG_AW-1:0] rs;
      logic [`REG_AW-1:0] rt;
      logic [`REG_AW-1:0] rd;
      logic [4:0]         shamt;
      logic [5:0]         funct;
   } rFmtT;

   // immediate-format view
   typedef struct packed {
      logic [5:0]         opcode;
      logic [`REG_AW-1:0] rs;
      logic [`REG_AW-1:0] rt;
      logic [15:0]        imm16;
   } iFmtT;

   // jump-format view
   typedef struct packed {
      logic [5:0]  opcode;
      logic [25:0] target26;
   } jFmtT;

   // same 32 bits, decoded by whichever view the opcode calls for
   typedef union packed {
      rFmtT rFmt;
      iFmtT iFmt;
      jFmtT jFmt;
   } instrWordT;

   // zero encodings are the bubble values
   typedef enum logic [2:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluLui
   } aluOpT;

   typedef enum logic [2:0] {
      memNone, memLoadWord, memLoadByte, memLoadByteU, memStoreWord, memStoreByte
   } memKindT;

   // one transfer on the program-load port
   typedef struct packed {
      logic [`IMEM_AW-1:0] addr;
      instrWordT           word;
   } loadWordT;

   // instruction memory write from the loader
   typedef struct packed {
      logic                en;
      logic [`IMEM_AW-1:0] addr;
      instrWordT           word;
   } imemWriteT;

   // PC change resolved in execute
   typedef struct packed {
      logic               valid;
      logic [`WORD_W-1:0] target;
   } redirectT;

   typedef struct packed {
      aluOpT              aluOp;
      logic               useImm;
      memKindT            memKind;
      logic               regWrite;
      logic [`REG_AW-1:0] dest;
      logic               linkPc;
      logic               isBranchEq;
      logic               isBranchNe;
      logic               isJump;
      logic               isJumpReg;
   } execCtlT;

   // F/E pipeline register
   typedef struct packed {
      execCtlT            ctl;
      logic [`REG_AW-1:0] rs;
      logic [`REG_AW-1:0] rt;
      logic [`WORD_W-1:0] rd1;
      logic [`WORD_W-1:0] rd2;
      logic [`WORD_W-1:0] imm;
      logic [25:0]        target26;
      logic [`WORD_W-1:0] pc;
   } fetchToExecT;

   // data memory access, word addressed with lane enables
   typedef struct packed {
      logic [`DMEM_AW-1:0] addr;
      logic [`WORD_W-1:0]  wdata;
      logic [3:0]          byteEn;
   } memReqT;

   // E/M pipeline register
   typedef struct packed {
      logic               regWrite;
      logic [`REG_AW-1:0] dest;
      memKindT            memKind;
      logic [1:0]         byteOffset;
      logic               link;
      logic [`WORD_W-1:0] aluResult;
      logic [`WORD_W-1:0] linkValue;
   } execToMemT;

   // final write-back, also the forwarding source
   typedef struct packed {
      logic               valid;
      logic [`REG_AW-1:0] dest;
      logic [`WORD_W-1:0] value;
   } commitT;

endpackage

`default_nettype wire

// ==== design/coreDefines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and address width
`define WORD_W  32
// register index width
`define REG_AW  5
// word-address widths of the two memories, 256 words each
`define IMEM_AW 8
`define DMEM_AW 8

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0a
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_XORI  6'h0e
`define OP_LUI   6'h0f
`define OP_LB    6'h20
`define OP_LW    6'h23
`define OP_LBU   6'h24
`define OP_SB    6'h28
`define OP_SW    6'h2b

// function codes of the R-type group
`define FN_JR   6'h08
`define FN_JALR 6'h09
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2a

// jal writes its return address here
`define LINK_REG 5'd31

`endif
